/* files.f */
+incdir+src
src/alu_flags_pkg.sv
src/alu_op_pkg.sv
src/carry_group_if.sv
src/stage_reg.sv
src/operand_prep.sv
src/group_adder.sv
src/flag_merge.sv
src/int_alu.sv
bench/int_alu_tb.sv

/* bench/int_alu_tb.sv */
`include "alu_cfg.svh"
`default_nettype none

module int_alu_tb
	import alu_op_pkg::*;
	import alu_flags_pkg::*;
;

	localparam int num_directed = 20;
	localparam int num_random   = 500;
	localparam int num_mid      = 6;
	localparam int num_after    = 3;
	localparam int num_requests = num_directed + num_random + num_mid + num_after;
	// Reset, idle and drain cycles fit well inside the margin
	localparam int watchdog_limit = (num_requests + 40) * 10;

	localparam alu_word_t max_pos = {1'b0, {(`ALU_WIDTH-1){1'b1}}};
	localparam alu_word_t min_neg = {1'b1, {(`ALU_WIDTH-1){1'b0}}};
	localparam eflags_t   df_only = eflags_t'(1) << `EFL_DF;

	logic      clk;
	logic      rst_n;
	logic      start;
	alu_op_t   op;
	alu_word_t a;
	alu_word_t b;
	eflags_t   flags_in;
	alu_word_t result;
	eflags_t   flags;
	logic      done;

	integer          seed = 32'h08e7f4a0;
	result_payload_t exp_q[$];
	int unsigned     due_q[$];
	result_payload_t exp_item;
	int unsigned     neg_cnt = 0;

	int_alu u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.op       (op),
		.a        (a),
		.b        (b),
		.flags_in (flags_in),
		.result   (result),
		.flags    (flags),
		.done     (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Reference model and reporting
	// ----------------------------------------------------------------------

	// x86 arithmetic flag rules on whole words
	function automatic result_payload_t ref_alu(input alu_op_t o, input alu_word_t x,
			input alu_word_t y, input eflags_t f);
		result_payload_t     rp;
		logic [`ALU_WIDTH:0] wide;
		alu_word_t           r;
		logic                cf;
		logic                of;
		logic                af;
		int                  ones;
		case (o)
			op_add:
			begin
				wide = {1'b0, x} + {1'b0, y};
				r    = wide[`ALU_WIDTH-1:0];
				cf   = wide[`ALU_WIDTH];
				of   = (x[`ALU_WIDTH-1] == y[`ALU_WIDTH-1]) && (r[`ALU_WIDTH-1] != x[`ALU_WIDTH-1]);
				af   = x[4] ^ y[4] ^ r[4];
			end
			op_sub:
			begin
				r  = x - y;
				cf = (x < y);
				of = (x[`ALU_WIDTH-1] != y[`ALU_WIDTH-1]) && (r[`ALU_WIDTH-1] != x[`ALU_WIDTH-1]);
				af = x[4] ^ y[4] ^ r[4];
			end
			op_inc:
			begin
				r  = x + 1;
				cf = f[`EFL_CF];
				of = (x == max_pos);
				af = (x[3:0] == 4'hf);
			end
			default:
			begin
				r  = x - 1;
				cf = f[`EFL_CF];
				of = (x == min_neg);
				af = (x[3:0] == 4'h0);
			end
		endcase
		// Ones in the low byte
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones = ones + r[i];
		rp.result            = r;
		rp.flags             = '0;
		rp.flags[`EFL_RSVD1] = 1'b1;
		rp.flags[`EFL_CF]    = cf;
		rp.flags[`EFL_PF]    = ((ones % 2) == 0);
		rp.flags[`EFL_AF]    = af;
		rp.flags[`EFL_ZF]    = (r == '0);
		rp.flags[`EFL_SF]    = r[`ALU_WIDTH-1];
		rp.flags[`EFL_DF]    = f[`EFL_DF];
		rp.flags[`EFL_OF]    = of;
		return rp;
	endfunction

	function automatic flag_set_t decode_flags(input eflags_t f);
		flag_set_t s;
		s.of = f[`EFL_OF];
		s.df = f[`EFL_DF];
		s.sf = f[`EFL_SF];
		s.zf = f[`EFL_ZF];
		s.af = f[`EFL_AF];
		s.pf = f[`EFL_PF];
		s.cf = f[`EFL_CF];
		return s;
	endfunction

	task automatic abort_run;
		$display("*** FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_problem(input string msg);
		$display("[ERROR] t=%0t %s", $time, msg);
		abort_run();
	endtask

	task automatic check_word(input string name, input alu_word_t got, input alu_word_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flags(input eflags_t got, input eflags_t exp);
		flag_set_t gs;
		flag_set_t es;
		gs = decode_flags(got);
		es = decode_flags(exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t flags got=%h exp=%h (odszapc got=%b exp=%b)",
				$time, got, exp, gs, es);
			abort_run();
		end
	endtask

	// ----------------------------------------------------------------------
	// Scoreboard, sampled at the falling edge
	// ----------------------------------------------------------------------
	always @(negedge clk)
	begin
		neg_cnt = neg_cnt + 1;
		if (!rst_n)
		begin
			// Anything in flight is lost
			exp_q.delete();
			due_q.delete();
		end
		else
		begin
			if (done)
			begin
				if (exp_q.size() == 0)
					report_problem("done pulsed with no request outstanding");
				if (due_q[0] != neg_cnt)
					report_problem("done arrived earlier than two cycles after its start");
				exp_item = exp_q.pop_front();
				void'(due_q.pop_front());
				check_word("result", result, exp_item.result);
				check_flags(flags, exp_item.flags);
			end
			else if (due_q.size() != 0 && due_q[0] <= neg_cnt)
				report_problem("no done two cycles after a start");

			if (start)
			begin
				exp_q.push_back(ref_alu(op, a, b, flags_in));
				due_q.push_back(neg_cnt + 2);
			end
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	task automatic issue(input alu_op_t o, input alu_word_t x, input alu_word_t y,
			input eflags_t f);
		@(posedge clk);
		start    <= 1'b1;
		op       <= o;
		a        <= x;
		b        <= y;
		flags_in <= f;
	endtask

	task automatic issue_random;
		logic [31:0] rnd;
		alu_word_t   x;
		alu_word_t   y;
		rnd = $random(seed);
		x   = $random(seed);
		y   = $random(seed);
		// Equal operands now and then to reach zero results
		if (rnd[3:2] == 2'b00)
			y = x;
		issue(alu_op_t'(rnd[1:0]), x, y, eflags_t'($random(seed)));
	endtask

	task automatic finish_traffic;
		@(posedge clk);
		start <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	initial
	begin
		#(watchdog_limit);
		report_problem("watchdog expired before the test finished");
	end

	initial
	begin
		rst_n    = 1'b0;
		start    = 1'b0;
		op       = op_add;
		a        = '0;
		b        = '0;
		flags_in = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// ADD carry, overflow, zero and parity
		issue(op_add, '1, 32'h1, '0);
		issue(op_add, max_pos, 32'h1, '0);
		issue(op_add, '0, '0, '0);
		issue(op_add, 32'h2, 32'h1, '0);
		issue(op_add, 32'h12345678, 32'h87654321, '0);
		// SUB borrow and AF
		issue(op_sub, 32'h5, 32'h5, '0);
		issue(op_sub, '0, 32'h1, '0);
		issue(op_sub, min_neg, 32'h1, '0);
		issue(op_sub, 32'h10, 32'h1, '0);
		// INC and DEC keep CF either way
		issue(op_inc, 32'h5, '0, '0);
		issue(op_inc, 32'h5, '0, eflags_t'(1));
		issue(op_inc, '1, '0, '0);
		issue(op_inc, '1, '0, eflags_t'(1));
		issue(op_dec, min_neg, '0, '0);
		issue(op_dec, min_neg, '0, eflags_t'(1));
		issue(op_dec, '0, '0, '0);
		issue(op_dec, 32'h1, '0, eflags_t'(1));
		// DF passes through, nothing else leaks
		issue(op_add, 32'h1, 32'h2, df_only);
		issue(op_sub, 32'h3, 32'h7, '1);
		issue(op_inc, max_pos, '0, df_only);

		repeat (num_random) issue_random();
		finish_traffic();

		// Reset with requests in flight
		repeat (num_mid) issue_random();
		@(posedge clk);
		rst_n <= 1'b0;
		start <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4)
		begin
			@(negedge clk);
			if (done)
				report_problem("done high after reset with no new start");
			check_word("result", result, '0);
			check_flags(flags, '0);
		end

		issue(op_add, 32'hff, 32'h1, '0);
		issue(op_sub, 32'h1, 32'h2, df_only);
		issue(op_dec, 32'h10, '0, eflags_t'(1));
		finish_traffic();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* src/int_alu.sv */
`include "alu_cfg.svh"
`default_nettype none

// Two-stage ADD/SUB/INC/DEC unit with EFLAGS output
module int_alu
	import alu_op_pkg::*;
	import alu_flags_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  alu_op_t   op,
	input  alu_word_t a,
	input  alu_word_t b,
	input  eflags_t   flags_in,
	output alu_word_t result,
	output eflags_t   flags,
	output logic      done
);

	carry_group_if grp [`ALU_GROUPS] ();

	alu_ctx_t ctx;
	logic     ctx_valid;

	operand_prep u_prep (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.op        (op),
		.a         (a),
		.b         (b),
		.flags_in  (flags_in),
		.groups    (grp),
		.ctx       (ctx),
		.ctx_valid (ctx_valid)
	);

	// One adder per lookahead group
	for (genvar gi = 0; gi < `ALU_GROUPS; gi++)
	begin : g_lane
		group_adder u_adder (
			.grp (grp[gi])
		);
	end

	flag_merge u_merge (
		.clk       (clk),
		.rst_n     (rst_n),
		.groups    (grp),
		.ctx       (ctx),
		.ctx_valid (ctx_valid),
		.result    (result),
		.flags     (flags),
		.done      (done)
	);

endmodule

`default_nettype wire

/* src/flag_merge.sv */
`include "alu_cfg.svh"
`default_nettype none

module flag_merge
	import alu_op_pkg::*;
	import alu_flags_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	carry_group_if.drain groups [`ALU_GROUPS],
	input  alu_ctx_t     ctx,
	input  logic         ctx_valid,
	output alu_word_t    result,
	output eflags_t      flags,
	output logic         done
);

	// Bits that may ever be set in the flags word
	localparam eflags_t flag_mask = eflags_t'((1 << `EFL_CF) | (1 << `EFL_RSVD1)
		| (1 << `EFL_PF) | (1 << `EFL_AF) | (1 << `EFL_ZF) | (1 << `EFL_SF)
		| (1 << `EFL_DF) | (1 << `EFL_OF));

	alu_word_t       sum_word;
	flag_set_t       fs;
	eflags_t         flags_d;
	result_payload_t res_d;
	result_payload_t res_q;
	logic            final_carry;
	logic            top_carry;
	logic            nib_carry;

	for (genvar gi = 0; gi < `ALU_GROUPS; gi++)
	begin : g_drain
		assign sum_word[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS] = groups[gi].sum;

		if (gi > 0)
		begin : g_chain
			// Lookahead carry into this group matches the adder below it
			a_carry_chain: assert property (@(posedge clk) disable iff (!rst_n)
				ctx_valid |-> ((groups[gi].a[0] ^ groups[gi].b[0] ^ groups[gi].sum[0])
					== groups[gi-1].carry_out))
				else $error("flag_merge: carry chain broken into group %0d", gi);
		end
	end

	assign final_carry = groups[`ALU_GROUPS-1].carry_out;
	assign top_carry   = groups[`ALU_GROUPS-1].top_carry_in;
	assign nib_carry   = groups[0].carry_out;

	// ---------------------------------------------------------------------
	// Flag rules
	// ---------------------------------------------------------------------
	always_comb
	begin
		fs.of = top_carry ^ final_carry;
		fs.df = ctx.flags[`EFL_DF];
		fs.sf = sum_word[`ALU_WIDTH-1];
		fs.zf = (sum_word == '0);
		fs.pf = ~^sum_word[7:0];

		// INC and DEC leave CF alone
		case (ctx.op)
			op_add:  fs.cf = final_carry;
			op_sub:  fs.cf = ~final_carry;
			default: fs.cf = ctx.flags[`EFL_CF];
		endcase

		// Borrow sense on the subtracting ops
		if (ctx.op == op_sub || ctx.op == op_dec)
			fs.af = ~nib_carry;
		else
			fs.af = nib_carry;
	end

	always_comb
	begin
		flags_d             = '0;
		flags_d[`EFL_RSVD1] = 1'b1;
		flags_d[`EFL_CF]    = fs.cf;
		flags_d[`EFL_PF]    = fs.pf;
		flags_d[`EFL_AF]    = fs.af;
		flags_d[`EFL_ZF]    = fs.zf;
		flags_d[`EFL_SF]    = fs.sf;
		flags_d[`EFL_DF]    = fs.df;
		flags_d[`EFL_OF]    = fs.of;
	end

	assign res_d = '{result: sum_word, flags: flags_d};

	stage_reg #(.T(result_payload_t)) u_out_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (ctx_valid),
		.in_data   (res_d),
		.out_valid (done),
		.out_data  (res_q)
	);

	assign result = res_q.result;
	assign flags  = res_q.flags;

	a_done_follows: assert property (@(posedge clk) disable iff (!rst_n)
		ctx_valid |=> done)
		else $error("flag_merge: done missing after ctx_valid");

	a_done_origin: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(ctx_valid))
		else $error("flag_merge: done without ctx_valid a cycle before");

	a_flags_shape: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (flags[`EFL_RSVD1] && ((flags & ~flag_mask) == '0)))
		else $error("flag_merge: bad reserved bits in flags %h", flags);

endmodule

`default_nettype wire

/* src/group_adder.sv */
`include "alu_cfg.svh"
`default_nettype none

// One 4-bit slice, carries looked ahead inside the group
module group_adder (
	carry_group_if.lane grp
);

	logic [`ALU_GROUP_BITS-1:0] g;
	logic [`ALU_GROUP_BITS-1:0] p;
	logic [`ALU_GROUP_BITS-1:0] c;

	assign g = grp.a & grp.b;
	assign p = grp.a ^ grp.b;

	// Carry into each bit straight from the group carry-in
	assign c[0] = grp.carry_in;
	assign c[1] = g[0] | (p[0] & grp.carry_in);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & grp.carry_in);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & grp.carry_in);

	assign grp.sum = p ^ c;

	assign grp.carry_out = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]) | (p[3] & p[2] & p[1] & p[0] & grp.carry_in);

	assign grp.top_carry_in = c[3];

endmodule

`default_nettype wire

/* src/operand_prep.sv */
`include "alu_cfg.svh"
`default_nettype none

module operand_prep
	import alu_op_pkg::*;
	import alu_flags_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  alu_op_t     op,
	input  alu_word_t   a,
	input  alu_word_t   b,
	input  eflags_t     flags_in,
	carry_group_if.feed groups [`ALU_GROUPS],
	output alu_ctx_t    ctx,
	output logic        ctx_valid
);

	prep_payload_t prep_d;
	prep_payload_t prep_q;
	alu_word_t     b_prep;
	logic          cin_prep;

	logic [`ALU_GROUPS-1:0] grp_gen;
	logic [`ALU_GROUPS-1:0] grp_prop;
	logic [`ALU_GROUPS-1:0] grp_cin;
	logic                   half_gen;
	logic                   half_prop;
	logic                   half_cin;

	// Generate out of a block of four
	function automatic logic block_gen(input logic [3:0] g, input logic [3:0] p);
		return g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
	endfunction

	// Carries into each member of a block of four
	function automatic logic [3:0] block_carries(input logic [3:0] g, input logic [3:0] p,
			input logic c0);
		logic [3:0] c;
		c[0] = c0;
		c[1] = g[0] | (p[0] & c0);
		c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0);
		c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & c0);
		return c;
	endfunction

	// ---------------------------------------------------------------------
	// Operand forming and the request register
	// ---------------------------------------------------------------------

	// SUB adds ~b plus one, INC/DEC add 0+1 and all ones
	always_comb
	begin
		case (op)
			op_sub:  b_prep = ~b;
			op_inc:  b_prep = '0;
			op_dec:  b_prep = '1;
			default: b_prep = b;
		endcase
	end

	assign cin_prep = (op == op_sub) || (op == op_inc);

	assign prep_d = '{a: a, b: b_prep, carry_in: cin_prep, ctx: '{op: op, flags: flags_in}};

	stage_reg #(.T(prep_payload_t)) u_prep_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (start),
		.in_data   (prep_d),
		.out_valid (ctx_valid),
		.out_data  (prep_q)
	);

	assign ctx = prep_q.ctx;

	// ---------------------------------------------------------------------
	// Group lookahead off the registered operands
	// ---------------------------------------------------------------------

	for (genvar gi = 0; gi < `ALU_GROUPS; gi++)
	begin : g_group
		logic [`ALU_GROUP_BITS-1:0] bit_g;
		logic [`ALU_GROUP_BITS-1:0] bit_p;

		assign bit_g = prep_q.a[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS]
			& prep_q.b[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS];
		assign bit_p = prep_q.a[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS]
			^ prep_q.b[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS];

		assign grp_gen[gi]  = block_gen(bit_g, bit_p);
		assign grp_prop[gi] = &bit_p;

		assign groups[gi].a        = prep_q.a[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS];
		assign groups[gi].b        = prep_q.b[gi*`ALU_GROUP_BITS +: `ALU_GROUP_BITS];
		assign groups[gi].carry_in = grp_cin[gi];
	end

	// Second level, low half of groups feeds the carry into group 4
	assign half_gen  = block_gen(grp_gen[3:0], grp_prop[3:0]);
	assign half_prop = &grp_prop[3:0];
	assign half_cin  = half_gen | (half_prop & prep_q.carry_in);

	assign grp_cin[3:0] = block_carries(grp_gen[3:0], grp_prop[3:0], prep_q.carry_in);
	assign grp_cin[7:4] = block_carries(grp_gen[7:4], grp_prop[7:4], half_cin);

	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !$isunknown(op))
		else $error("operand_prep: op has unknown bits with start");

endmodule

`default_nettype wire

/* src/stage_reg.sv */
`default_nettype none

// Valid-qualified pipeline register for any payload type
module stage_reg #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  T     in_data,
	output logic out_valid,
	output T     out_data
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload holds between beats and reads zero out of reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_data <= '0;
		else if (in_valid)
			out_data <= in_data;
	end

endmodule

`default_nettype wire

/* src/carry_group_if.sv */
`include "alu_cfg.svh"
`default_nettype none

// One 4-bit lookahead group between prep, its adder and the flag stage
interface carry_group_if;

	logic [`ALU_GROUP_BITS-1:0] a;
	logic [`ALU_GROUP_BITS-1:0] b;
	logic                       carry_in;
	logic [`ALU_GROUP_BITS-1:0] sum;
	logic                       carry_out;
	// Carry into the top bit of the slice, needed for OF
	logic                       top_carry_in;

	modport feed (
		output a, b, carry_in
	);

	modport lane (
		input  a, b, carry_in,
		output sum, carry_out, top_carry_in
	);

	modport drain (
		input a, b, sum, carry_out, top_carry_in
	);

endinterface

`default_nettype wire

/* src/alu_op_pkg.sv */
`include "alu_cfg.svh"
`default_nettype none

package alu_op_pkg;

	import alu_flags_pkg::*;

	typedef logic [`ALU_WIDTH-1:0] alu_word_t;

	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_inc = 2'd2,
		op_dec = 2'd3
	} alu_op_t;

	// Travels beside the operands down to the flag stage
	typedef struct packed {
		alu_op_t op;
		eflags_t flags;
	} alu_ctx_t;

	// First stage payload, b already inverted or forced for the op
	typedef struct packed {
		alu_word_t a;
		alu_word_t b;
		logic      carry_in;
		alu_ctx_t  ctx;
	} prep_payload_t;

endpackage

`default_nettype wire

/* src/alu_flags_pkg.sv */
`include "alu_cfg.svh"
`default_nettype none

package alu_flags_pkg;

	// Whole EFLAGS image as seen on the ports
	typedef logic [`ALU_WIDTH-1:0] eflags_t;

	// Individual status bits before packing
	typedef struct packed {
		logic of;
		logic df;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} flag_set_t;

	// Output stage payload
	typedef struct packed {
		logic [`ALU_WIDTH-1:0] result;
		eflags_t               flags;
	} result_payload_t;

endpackage

`default_nettype wire

/* src/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

`default_nettype none

// Datapath geometry
`define ALU_WIDTH       32
`define ALU_GROUP_BITS  4
`define ALU_GROUPS      (`ALU_WIDTH / `ALU_GROUP_BITS)

// EFLAGS bit positions
`define EFL_CF     0
`define EFL_RSVD1  1
`define EFL_PF     2
`define EFL_AF     4
`define EFL_ZF     6
`define EFL_SF     7
`define EFL_DF     10
`define EFL_OF     11

`default_nettype wire

`endif
